/* renamePkg.sv */
/*
  Register namespace of the rename stage
  Sizes of the logical and physical register files and their index types.
  Imported wherever register indices are stored or compared
*/

package renamePkg;

  // Architectural registers seen by software
  localparam int numLogRegs = 32;

  // Physical register file behind the rename map
  localparam int numPhyRegs = 64;

  // Index widths follow from the file sizes
  localparam int logRegBits = $clog2(numLogRegs);
  localparam int phyRegBits = $clog2(numPhyRegs);

  // Logical register index, 5 bits
  typedef logic [logRegBits-1:0] logReg_t;

  // Physical register index, 6 bits
  typedef logic [phyRegBits-1:0] phyReg_t;

endpackage

/* commitPkg.sv */
/*
  Port bundles of the architectural map table
  Commit slots from the active list, release slots to the free list and
  recovery entries to the speculative rename table, plus the commit width
*/

package commitPkg;

  localparam int commitWidth = 4;  // Slots per cycle, also entries per walk step
  localparam int commitWidthLog2 = $clog2(commitWidth);

  // Base index of the final group in a table walk
  localparam renamePkg::logReg_t lastWalkBase =
    renamePkg::logReg_t'(renamePkg::numLogRegs - commitWidth);

  // One retiring instruction with a destination register
  typedef struct packed {
    logic valid;                   // Slot carries a destination
    renamePkg::logReg_t logDest;   // Logical destination
    renamePkg::phyReg_t phyDest;   // Newly committed physical register
  } commitSlot_t;

  // Register handed back to the free list
  typedef struct packed {
    logic valid;
    renamePkg::phyReg_t phyReg;
  } releaseSlot_t;

  // One table entry for rebuilding the rename table
  typedef struct packed {
    renamePkg::logReg_t logReg;
    renamePkg::phyReg_t phyReg;
  } recoverEntry_t;

endpackage

/* archMapRam.sv */
/*
  Committed map storage, one physical register per logical register
  Four asynchronous read ports and four synchronous write ports.
  Reset loads the identity mapping
*/

`timescale 1ns/10ps

module archMapRam (
  input  logic clk,
  input  logic reset,
  input  renamePkg::logReg_t readAddr_i [commitPkg::commitWidth],
  output renamePkg::phyReg_t readData_o [commitPkg::commitWidth],
  input  logic [commitPkg::commitWidth-1:0] writeEn_i,
  input  renamePkg::logReg_t writeAddr_i [commitPkg::commitWidth],
  input  renamePkg::phyReg_t writeData_i [commitPkg::commitWidth]
);
  import renamePkg::*;
  import commitPkg::*;

  phyReg_t mapTable [numLogRegs];  // Indexed by logical register
  logic writeConflict;             // Two enabled ports on one entry

  // Read ports see the table before this edge's writes
  always_comb begin
    for (int p = 0; p < commitWidth; p++) begin
      readData_o[p] = mapTable[readAddr_i[p]];
    end
  end

  // Identity mapping on reset, then up to four updates per cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int e = 0; e < numLogRegs; e++) begin
        mapTable[e] <= phyReg_t'(e);  // Logical e on physical e
      end
    end else begin
      for (int p = 0; p < commitWidth; p++) begin
        if (writeEn_i[p]) begin
          mapTable[writeAddr_i[p]] <= writeData_i[p];
        end
      end
    end
  end

  // Pairwise address compare across enabled write ports
  always_comb begin
    writeConflict = 1'b0;
    for (int a = 0; a < commitWidth; a++) begin
      for (int b = a + 1; b < commitWidth; b++) begin
        if (writeEn_i[a] && writeEn_i[b] && (writeAddr_i[a] == writeAddr_i[b])) begin
          writeConflict = 1'b1;
        end
      end
    end
  end

  // Youngest-wins filtering upstream leaves one writer per entry
  writeUniqueA: assert property (
    @(posedge clk) disable iff (reset) !writeConflict
  ) else $error("Map table written twice at one address in a cycle");

endmodule

/* commitFilter.sv */
/*
  Commit window filter for the architectural map table
  Only the youngest writer of a logical register updates the table.
  Picks the register each valid slot releases to the free list
*/

`timescale 1ns/10ps

module commitFilter (
  input  commitPkg::commitSlot_t commitSlots_i [commitPkg::commitWidth],
  input  renamePkg::phyReg_t tableData_i [commitPkg::commitWidth],
  output logic [commitPkg::commitWidth-1:0] writeEn_o,
  output renamePkg::logReg_t writeAddr_o [commitPkg::commitWidth],
  output renamePkg::phyReg_t writeData_o [commitPkg::commitWidth],
  output commitPkg::releaseSlot_t releaseSlots_o [commitPkg::commitWidth],
  input  logic recoverFlag_i
);
  import commitPkg::*;

  logic [commitWidth-1:0] overridden;  // A younger valid slot hits the same register
  logic [commitWidth-1:0] slotValid;

  always_comb begin
    for (int i = 0; i < commitWidth; i++) begin
      slotValid[i] = commitSlots_i[i].valid;
    end
  end

  // Compare each slot against every younger one in the window
  always_comb begin
    for (int i = 0; i < commitWidth; i++) begin
      overridden[i] = 1'b0;
      for (int j = i + 1; j < commitWidth; j++) begin
        if (commitSlots_i[j].valid &&
            (commitSlots_i[j].logDest == commitSlots_i[i].logDest)) begin
          overridden[i] = 1'b1;
        end
      end
    end
  end

  // Table update, youngest writer only
  always_comb begin
    for (int i = 0; i < commitWidth; i++) begin
      writeEn_o[i]   = slotValid[i] & ~overridden[i];
      writeAddr_o[i] = commitSlots_i[i].logDest;
      writeData_o[i] = commitSlots_i[i].phyDest;
    end
  end

  // Released register per slot
  // Youngest writer frees the old committed mapping,
  // an overridden slot frees its own register since it never becomes architectural
  always_comb begin
    for (int i = 0; i < commitWidth; i++) begin
      releaseSlots_o[i].valid  = slotValid[i];
      releaseSlots_o[i].phyReg = overridden[i] ? commitSlots_i[i].phyDest
                                               : tableData_i[i];
    end
  end

  // Read ports belong to the walker during recovery
  always_comb begin
    noCommitInWalkA: assert #0 (!(recoverFlag_i && (|slotValid)))
      else $error("Commit slot valid during recovery walk");
  end

endmodule

/* recoveryWalker.sv */
/*
  Recovery walk control for the architectural map table
  Steps a group pointer through the table while the recover flag is high
  and flags the final group. Pointer sits at zero otherwise
*/

`timescale 1ns/10ps

module recoveryWalker (
  input  logic clk,
  input  logic reset,
  input  logic recoverFlag_i,
  output renamePkg::logReg_t walkBase_o,
  output logic recoverDone_o
);
  import renamePkg::*;
  import commitPkg::*;

  logReg_t walkPtr;   // First entry of the group on the read ports
  logic lastGroup;

  assign lastGroup = (walkPtr == lastWalkBase);

  always_ff @(posedge clk) begin
    if (reset) begin
      walkPtr <= '0;
    end else if (recoverFlag_i) begin
      if (lastGroup) begin
        walkPtr <= '0;  // Wrap after entries 28 to 31
      end else begin
        walkPtr <= walkPtr + logReg_t'(commitWidth);
      end
    end else begin
      walkPtr <= '0;  // Dropped walk restarts from entry 0
    end
  end

  assign walkBase_o    = walkPtr;
  assign recoverDone_o = recoverFlag_i & lastGroup;  // Final group of the walk

  // Groups always start on a commitWidth boundary
  walkAlignedA: assert property (
    @(posedge clk) disable iff (reset)
    walkPtr[commitWidthLog2-1:0] == '0
  ) else $error("Walk pointer off group boundary");

endmodule

/* archMapTable.sv */
/*
  Architectural map table of the rename stage
  Takes up to four commits per cycle, releases freed registers and
  streams the committed map out four entries per cycle on recovery
*/

`timescale 1ns/10ps

module archMapTable (
  input  logic clk,
  input  logic reset,
  input  commitPkg::commitSlot_t commitSlots_i [commitPkg::commitWidth],
  input  logic recoverFlag_i,
  output commitPkg::releaseSlot_t releaseSlots_o [commitPkg::commitWidth],
  output commitPkg::recoverEntry_t recoverEntries_o [commitPkg::commitWidth],
  output logic recoverDone_o
);
  import renamePkg::*;
  import commitPkg::*;

  logReg_t readAddr [commitWidth];
  phyReg_t readData [commitWidth];
  logic [commitWidth-1:0] writeEn;
  logReg_t writeAddr [commitWidth];
  phyReg_t writeData [commitWidth];
  logReg_t walkBase;  // Group base from the walker

  // Read port owner is the walker on recovery, else the commit slots
  always_comb begin
    for (int p = 0; p < commitWidth; p++) begin
      readAddr[p] = recoverFlag_i ? walkBase + logReg_t'(p) : commitSlots_i[p].logDest;
      recoverEntries_o[p].logReg = walkBase + logReg_t'(p);
      recoverEntries_o[p].phyReg = readData[p];
    end
  end

  commitFilter commitFilter_inst (
    .commitSlots_i  (commitSlots_i),
    .tableData_i    (readData),
    .writeEn_o      (writeEn),
    .writeAddr_o    (writeAddr),
    .writeData_o    (writeData),
    .releaseSlots_o (releaseSlots_o),
    .recoverFlag_i  (recoverFlag_i)
  );

  recoveryWalker recoveryWalker_inst (
    .clk           (clk),
    .reset         (reset),
    .recoverFlag_i (recoverFlag_i),
    .walkBase_o    (walkBase),
    .recoverDone_o (recoverDone_o)
  );

  archMapRam archMapRam_inst (
    .clk         (clk),
    .reset       (reset),
    .readAddr_i  (readAddr),
    .readData_o  (readData),
    .writeEn_i   (writeEn),
    .writeAddr_i (writeAddr),
    .writeData_i (writeData)
  );

endmodule

/* archMapChecker.sv */
/*
  Scoreboard for the map table testbench
  Compares release slots, recovery entries and the done flag with the
  expected values from the testbench model at every rising edge
*/

`timescale 1ns/10ps

module archMapChecker (
  input  logic clk,
  input  logic reset,
  input  commitPkg::releaseSlot_t releaseSlots_i [commitPkg::commitWidth],
  input  commitPkg::recoverEntry_t recoverEntries_i [commitPkg::commitWidth],
  input  logic recoverDone_i,
  input  commitPkg::releaseSlot_t expRelease_i [commitPkg::commitWidth],
  input  commitPkg::recoverEntry_t expEntries_i [commitPkg::commitWidth],
  input  logic expDone_i,
  input  logic walkActive_i,   // Entries only meaningful during a walk
  output int errorCount_o,
  output int checkCount_o
);
  import commitPkg::*;

  int errors = 0;
  int checks = 0;

  assign errorCount_o = errors;
  assign checkCount_o = checks;

  // Outputs stay stable from the falling edge until the table updates
  always @(posedge clk) begin
    if (!reset) begin
      for (int p = 0; p < commitWidth; p++) begin
        checks++;
        // Register number only matters for a valid release
        if ((releaseSlots_i[p].valid !== expRelease_i[p].valid) ||
            (expRelease_i[p].valid && (releaseSlots_i[p].phyReg !== expRelease_i[p].phyReg))) begin
          $display("mismatch releaseSlots_o[%0d] got %h expected %h",
                   p, releaseSlots_i[p], expRelease_i[p]);
          errors++;
        end
        if (walkActive_i) begin
          checks++;
          if (recoverEntries_i[p] !== expEntries_i[p]) begin
            $display("mismatch recoverEntries_o[%0d] got %h expected %h",
                     p, recoverEntries_i[p], expEntries_i[p]);
            errors++;
          end
        end
      end
      checks++;
      if (recoverDone_i !== expDone_i) begin  // Done only on the final group
        $display("mismatch recoverDone_o got %h expected %h", recoverDone_i, expDone_i);
        errors++;
      end
    end
  end

endmodule

/* archMapTableTb.sv */
/*
  Testbench for the architectural map table
  Drives commit windows and recovery walks on the falling edge, keeps a
  model table and free list, and hands expected values to the checker
*/

`timescale 1ns/10ps

module archMapTableTb;
  import renamePkg::*;
  import commitPkg::*;

  localparam int clkPeriod = 100;
  localparam int resetCycles = 3;
  localparam int walkGroups = numLogRegs / commitWidth;  // 8 groups per walk
  localparam int randWindows = 300;
  localparam int directedCycles = 40;
  localparam int totalCycles = resetCycles + 6 * (2 * walkGroups + 2) + directedCycles
                               + randWindows;

  logic clk;
  logic reset;
  logic recoverFlag;
  logic recoverDone;
  commitSlot_t commitSlots [commitWidth];
  releaseSlot_t releaseSlots [commitWidth];
  recoverEntry_t recoverEntries [commitWidth];

  phyReg_t modelTable [numLogRegs];  // Expected committed map
  phyReg_t freeRegs [$];             // Registers not mapped anywhere
  releaseSlot_t expRelease [commitWidth];
  recoverEntry_t expEntries [commitWidth];
  logic expDone;
  logic walkActive;
  int errorCount;
  int checkCount;
  int testCount = 0;
  int testStartErrors = 0;

  archMapTable archMapTable_inst (
    .clk              (clk),
    .reset            (reset),
    .commitSlots_i    (commitSlots),
    .recoverFlag_i    (recoverFlag),
    .releaseSlots_o   (releaseSlots),
    .recoverEntries_o (recoverEntries),
    .recoverDone_o    (recoverDone)
  );

  archMapChecker archMapChecker_inst (
    .clk              (clk),
    .reset            (reset),
    .releaseSlots_i   (releaseSlots),
    .recoverEntries_i (recoverEntries),
    .recoverDone_i    (recoverDone),
    .expRelease_i     (expRelease),
    .expEntries_i     (expEntries),
    .expDone_i        (expDone),
    .walkActive_i     (walkActive),
    .errorCount_o     (errorCount),
    .checkCount_o     (checkCount)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  // Reference model for one window
  // Releases read the table as it was before the window
  function automatic void predictWindow();
    logic [numLogRegs-1:0] claimed;  // Registers already written by a younger slot
    claimed = '0;
    // Youngest first, so the first valid writer seen owns the old mapping
    for (int i = commitWidth - 1; i >= 0; i--) begin
      expRelease[i].valid = commitSlots[i].valid;
      if (claimed[commitSlots[i].logDest]) begin
        expRelease[i].phyReg = commitSlots[i].phyDest;  // Never becomes architectural
      end else begin
        expRelease[i].phyReg = modelTable[commitSlots[i].logDest];
      end
      if (commitSlots[i].valid) begin
        claimed[commitSlots[i].logDest] = 1'b1;
      end
    end
    // In program order, so the youngest write lands last
    for (int i = 0; i < commitWidth; i++) begin
      if (commitSlots[i].valid) begin
        modelTable[commitSlots[i].logDest] = commitSlots[i].phyDest;
      end
    end
  endfunction

  // Falling edge, all slots empty, no walk
  task automatic nextCycle();
    @(negedge clk);
    recoverFlag = 1'b0;
    walkActive  = 1'b0;
    expDone     = 1'b0;
    for (int i = 0; i < commitWidth; i++) begin
      commitSlots[i] = '0;
      expRelease[i]  = '0;
    end
  endtask

  // Valid slots take a fresh register off the free list
  task automatic setSlot(int idx, logic valid, int dest);
    commitSlots[idx].valid   = valid;
    commitSlots[idx].logDest = logReg_t'(dest);
    commitSlots[idx].phyDest = valid ? freeRegs.pop_front() : phyReg_t'($urandom);
  endtask

  task automatic finishWindow();
    predictWindow();
    for (int i = 0; i < commitWidth; i++) begin
      if (expRelease[i].valid) begin
        freeRegs.push_back(expRelease[i].phyReg);  // Freed register reusable
      end
    end
  endtask

  // Walk of the given number of groups, flag drops afterwards
  task automatic walkTable(int groups);
    logReg_t base;
    for (int g = 0; g < groups; g++) begin
      nextCycle();
      base        = logReg_t'((g % walkGroups) * commitWidth);
      recoverFlag = 1'b1;
      walkActive  = 1'b1;
      expDone     = ((g % walkGroups) == walkGroups - 1);
      for (int p = 0; p < commitWidth; p++) begin
        expEntries[p].logReg = base + logReg_t'(p);
        expEntries[p].phyReg = modelTable[base + logReg_t'(p)];
      end
    end
    nextCycle();
  endtask

  task automatic endTest(string name);
    nextCycle();  // Last window checked at the edge before
    testCount++;
    $display("Test %0d %s: %0d errors", testCount, name, errorCount - testStartErrors);
    testStartErrors = errorCount;
  endtask

  initial begin
    #((totalCycles + 50) * clkPeriod);
    $display("Watchdog: simulation did not finish within %0d ns", (totalCycles + 50) * clkPeriod);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    void'($urandom(97443));
    reset = 1'b1;
    recoverFlag = 1'b0;
    walkActive = 1'b0;
    expDone = 1'b0;
    for (int i = 0; i < commitWidth; i++) begin
      commitSlots[i] = '0;
      expRelease[i]  = '0;
      expEntries[i]  = '0;
    end
    for (int r = 0; r < numLogRegs; r++) begin
      modelTable[r] = phyReg_t'(r);  // Identity after reset
    end
    for (int f = numLogRegs; f < numPhyRegs; f++) begin
      freeRegs.push_back(phyReg_t'(f));
    end
    repeat (resetCycles) @(negedge clk);
    reset = 1'b0;

    walkTable(walkGroups);
    endTest("identity walk");

    for (int k = 0; k < commitWidth; k++) begin
      nextCycle();
      setSlot(k, 1'b1, 3 * k + 1);
      finishWindow();
    end
    walkTable(walkGroups);
    endTest("single commits");

    nextCycle();
    setSlot(0, 1'b1, 7);
    setSlot(1, 1'b1, 7);
    finishWindow();
    nextCycle();
    setSlot(0, 1'b1, 9);
    setSlot(1, 1'b1, 2);
    setSlot(2, 1'b1, 9);
    setSlot(3, 1'b1, 9);
    finishWindow();
    nextCycle();
    for (int k = 0; k < commitWidth; k++) begin
      setSlot(k, 1'b1, 12);  // Whole window on one register
    end
    finishWindow();
    walkTable(walkGroups);
    endTest("shared destinations");

    nextCycle();
    setSlot(0, 1'b1, 20);
    setSlot(1, 1'b0, 20);  // Invalid younger slot must not override
    setSlot(2, 1'b0, 20);
    setSlot(3, 1'b0, 21);
    finishWindow();
    nextCycle();
    setSlot(0, 1'b0, 22);
    setSlot(2, 1'b1, 22);
    setSlot(3, 1'b0, 22);
    finishWindow();
    walkTable(walkGroups);
    endTest("invalid slots");

    for (int w = 0; w < randWindows; w++) begin
      nextCycle();
      for (int i = 0; i < commitWidth; i++) begin
        // Narrow range half the time for frequent collisions
        setSlot(i, ($urandom % 4) != 0, ($urandom % 2) ? $urandom % 6 : $urandom % numLogRegs);
      end
      finishWindow();
    end
    walkTable(walkGroups);
    endTest("random windows");

    walkTable(walkGroups + walkGroups / 2);  // One wrap then flag drops halfway
    walkTable(walkGroups);
    endTest("restarted walk");

    $display("Summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* vlog.f */
renamePkg.sv
commitPkg.sv
archMapRam.sv
commitFilter.sv
recoveryWalker.sv
archMapTable.sv
archMapChecker.sv
archMapTableTb.sv
